// ==== flist.f ====
+incdir+verilog
verilog/cache_cpu_pkg.sv
verilog/cache_mem_pkg.sv
verilog/cache_front_end.sv
verilog/cache_memory.sv
verilog/cache_control.sv
verilog/cache_back_end.sv
verilog/cache_top.sv
sim/tb_mem_model.sv
sim/tb_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_cache -f flist.f -o tb_cache

out=$(./obj_dir/tb_cache)
echo "$out"

echo "$out" | grep -q "STATUS: PASS"

// ==== sim/tb_cache.sv ====
`timescale 1ns/10ps

`include "cache_defines.svh"

module tb_cache
   import cache_cpu_pkg::*;
   import cache_mem_pkg::*;
();

   localparam int wa_w           = `ADDR_W - `NBYTES_W;
   localparam int cycles_per_row = 60;
   localparam int max_rows       = 30;
   // reset and margin on top of the worst case per row
   localparam int cycle_limit    = max_rows * cycles_per_row + 200;

   typedef struct packed {
      logic                 we;
      logic                 is_ctrl;
      logic [wa_w-1:0]      addr;
      logic [`DATA_W-1:0]   wdata;
      logic [`NBYTES-1:0]   wstrb;
      logic [`DATA_W-1:0]   expected;
      logic                 check;
      logic                 pulse_inv;
   } row_t;

   logic               clk;
   logic               rst_n;
   logic               req;
   logic               ack;
   cpu_req_t           cpu_req;
   logic [`DATA_W-1:0] rdata;
   logic               mem_req;
   logic               mem_ack;
   mem_req_t           mem_cmd;
   mem_rsp_t           mem_rsp;
   logic               invalidate_in;
   logic               invalidate_out;

   row_t rows[$];
   int   errors = 0;
   int   cycles = 0;

   cache_top cache_top_i (.clk, .rst_n, .req, .ack, .cpu_req, .rdata, .mem_req, .mem_ack,
                          .mem_cmd, .mem_rsp, .invalidate_in, .invalidate_out);

   tb_mem_model mem_model (.clk, .mem_req, .mem_ack, .mem_cmd, .mem_rsp);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // external memory content before any write
   function automatic logic [`DATA_W-1:0] init_word(input logic [wa_w-1:0] addr);
      return {{(`DATA_W - wa_w){1'b0}}, addr} + 32'h1000_0000;
   endfunction

   function automatic logic [`DATA_W-1:0] merge_bytes(input logic [`DATA_W-1:0] old_word,
         input logic [`DATA_W-1:0] new_word, input logic [`NBYTES-1:0] strb);
      logic [`DATA_W-1:0] word;
      word = old_word;
      for (int b = 0; b < `NBYTES; b++)
         if (strb[b])
            word[8*b +: 8] = new_word[8*b +: 8];
      return word;
   endfunction

   task automatic add_row(input logic we, input logic is_ctrl, input logic [wa_w-1:0] addr,
         input logic [`DATA_W-1:0] wdata, input logic [`NBYTES-1:0] wstrb,
         input logic [`DATA_W-1:0] expected, input logic check, input logic pulse_inv);
      rows.push_back('{we, is_ctrl, addr, wdata, wstrb, expected, check, pulse_inv});
   endtask

   // one cycle on the chain input, checked on the falling edges around it
   task automatic pulse_invalidate_in();
      @(negedge clk);
      invalidate_in = 1'b1;
      @(negedge clk);
      if (invalidate_out !== 1'b1) begin
         $display("Mismatch at %0t: invalidate_out got %b expected 1", $time, invalidate_out);
         errors++;
      end
      invalidate_in = 1'b0;
      @(negedge clk);
      if (invalidate_out !== 1'b0) begin
         $display("Mismatch at %0t: invalidate_out got %b expected 0", $time, invalidate_out);
         errors++;
      end
   endtask

   // four-phase CPU access
   task automatic cpu_access(input row_t r, output logic [`DATA_W-1:0] data);
      @(negedge clk);
      cpu_req.we    = r.we;
      cpu_req.addr  = {r.is_ctrl, r.addr};
      cpu_req.wdata = r.wdata;
      cpu_req.wstrb = r.wstrb;
      req           = 1'b1;
      while (ack !== 1'b1)
         @(negedge clk);
      data = rdata;
      req  = 1'b0;
      while (ack !== 1'b0)
         @(negedge clk);
   endtask

   initial begin
      logic [`DATA_W-1:0] got;
      logic [`DATA_W-1:0] w_full;
      logic [`DATA_W-1:0] w_part;
      int                 errors_before;
      int                 passed;
      void'($urandom(31303));
      rst_n         = 1'b0;
      req           = 1'b0;
      cpu_req       = '0;
      invalidate_in = 1'b0;
      passed        = 0;
      w_full        = $urandom;
      w_part        = $urandom;

      // miss fills line 1, then hits in the same line
      add_row(1'b0, 1'b0, 14'h045, '0, 4'h0, init_word(14'h045), 1'b1, 1'b0);
      add_row(1'b0, 1'b0, 14'h046, '0, 4'h0, init_word(14'h046), 1'b1, 1'b0);
      add_row(1'b0, 1'b0, 14'h044, '0, 4'h0, init_word(14'h044), 1'b1, 1'b0);
      add_row(1'b0, 1'b1, 14'd1, '0, 4'h0, 32'd1, 1'b1, 1'b0);
      add_row(1'b0, 1'b1, 14'd0, '0, 4'h0, 32'd2, 1'b1, 1'b0);
      // write hit updates the cached line
      add_row(1'b1, 1'b0, 14'h047, w_full, 4'hf, '0, 1'b0, 1'b0);
      add_row(1'b0, 1'b0, 14'h047, '0, 4'h0, w_full, 1'b1, 1'b0);
      // partial write to an uncached line
      add_row(1'b1, 1'b0, 14'h208, w_part, 4'h5, '0, 1'b0, 1'b0);
      add_row(1'b0, 1'b1, 14'd2, '0, 4'h0, 32'd2, 1'b1, 1'b0);
      add_row(1'b0, 1'b1, 14'd0, '0, 4'h0, 32'd3, 1'b1, 1'b0);
      add_row(1'b0, 1'b1, 14'd1, '0, 4'h0, 32'd1, 1'b1, 1'b0);
      // register 3 invalidates and clears the counters
      add_row(1'b1, 1'b1, 14'd3, '0, 4'hf, '0, 1'b0, 1'b0);
      add_row(1'b0, 1'b1, 14'd0, '0, 4'h0, 32'd0, 1'b1, 1'b0);
      add_row(1'b0, 1'b1, 14'd1, '0, 4'h0, 32'd0, 1'b1, 1'b0);
      add_row(1'b0, 1'b1, 14'd2, '0, 4'h0, 32'd0, 1'b1, 1'b0);
      add_row(1'b0, 1'b0, 14'h208, '0, 4'h0, merge_bytes(init_word(14'h208), w_part, 4'h5),
              1'b1, 1'b0);
      add_row(1'b0, 1'b0, 14'h208, '0, 4'h0, merge_bytes(init_word(14'h208), w_part, 4'h5),
              1'b1, 1'b0);
      // refill line 1, then drop it through the chain input
      add_row(1'b0, 1'b0, 14'h045, '0, 4'h0, init_word(14'h045), 1'b1, 1'b0);
      add_row(1'b0, 1'b0, 14'h047, '0, 4'h0, w_full, 1'b1, 1'b0);
      add_row(1'b0, 1'b0, 14'h047, '0, 4'h0, w_full, 1'b1, 1'b1);
      // conflict on index 1 with another tag
      add_row(1'b0, 1'b0, 14'h005, '0, 4'h0, init_word(14'h005), 1'b1, 1'b0);
      add_row(1'b0, 1'b0, 14'h047, '0, 4'h0, w_full, 1'b1, 1'b0);
      add_row(1'b0, 1'b1, 14'd1, '0, 4'h0, 32'd5, 1'b1, 1'b0);
      add_row(1'b0, 1'b1, 14'd0, '0, 4'h0, 32'd2, 1'b1, 1'b0);
      add_row(1'b0, 1'b1, 14'd2, '0, 4'h0, 32'd0, 1'b1, 1'b0);

      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      foreach (rows[i]) begin
         errors_before = errors;
         if (rows[i].pulse_inv)
            pulse_invalidate_in();
         cpu_access(rows[i], got);
         if (rows[i].check && got !== rows[i].expected) begin
            $display("Mismatch at %0t: rdata in row %0d got %h expected %h",
                     $time, i, got, rows[i].expected);
            errors++;
         end
         if (errors == errors_before) begin
            passed++;
            $display("row %0d passed", i);
         end else begin
            $display("row %0d failed", i);
         end
      end

      $display("rows %0d, passed %0d, failed %0d", rows.size(), passed,
               rows.size() - passed);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// ==== sim/tb_mem_model.sv ====
`timescale 1ns/10ps

`include "cache_defines.svh"

module tb_mem_model
   import cache_mem_pkg::*;
(
   input  logic     clk,
   input  logic     mem_req,
   output logic     mem_ack,
   input  mem_req_t mem_cmd,
   output mem_rsp_t mem_rsp
);

   localparam int words = 1 << (`ADDR_W - `NBYTES_W);

   logic [`DATA_W-1:0] mem [0:words-1];

   // every word starts as its own word address above a fixed base
   initial begin
      for (int a = 0; a < words; a++)
         mem[a] = a + 32'h1000_0000;
   end

   // slave side of the four-phase exchange, driven on falling edges
   initial begin
      int unsigned delay;
      mem_ack = 1'b0;
      mem_rsp = '0;
      forever begin
         @(negedge clk);
         if (mem_req && !mem_ack) begin
            delay = $urandom % 4;
            repeat (delay) @(negedge clk);
            if (mem_cmd.we) begin
               for (int b = 0; b < `NBYTES; b++)
                  if (mem_cmd.wstrb[b])
                     mem[mem_cmd.addr][8*b +: 8] = mem_cmd.wdata[8*b +: 8];
            end else begin
               mem_rsp.rdata = mem[mem_cmd.addr];
            end
            mem_ack = 1'b1;
         end else if (!mem_req && mem_ack) begin
            mem_ack = 1'b0;
         end
      end
   end

endmodule

// ==== verilog/cache_back_end.sv ====
`timescale 1ns/10ps

module cache_back_end
   import cache_mem_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     be_start,
   input  mem_req_t be_cmd,
   output logic     be_done,
   output mem_rsp_t be_rsp,
   output logic     mem_req,
   input  logic     mem_ack,
   output mem_req_t mem_cmd,
   input  mem_rsp_t mem_rsp
);

   typedef enum logic [1:0] {st_idle, st_req, st_release, st_done} state_t;

   state_t   state;
   mem_req_t cmd_q;
   mem_rsp_t rsp_q;

   // outputs decoded straight from the state register
   assign mem_req = (state == st_req);
   assign be_done = (state == st_done);
   assign mem_cmd = cmd_q;
   assign be_rsp  = rsp_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle:    if (be_start) state <= st_req;
            st_req:     if (mem_ack) state <= st_release;
            // wait for the slave to drop ack before finishing
            st_release: if (!mem_ack) state <= st_done;
            st_done:    state <= st_idle;
            default:    state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_idle && be_start)
         cmd_q <= be_cmd;
      if (state == st_req && mem_ack)
         rsp_q <= mem_rsp;
   end

endmodule

// ==== verilog/cache_control.sv ====
`timescale 1ns/10ps

`include "cache_defines.svh"

module cache_control
   import cache_cpu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  cpu_req_t  lat_req,
   input  logic      ctrl_start,
   output part_rsp_t ctrl_rsp,
   input  logic      read_hit,
   input  logic      read_miss,
   input  logic      write,
   output logic      invalidate
);

   ctrl_reg_e          reg_sel;
   logic               clear;
   logic [2:0]         events;
   logic [`DATA_W-1:0] cnt [0:2];
   logic               done_q;
   logic [`DATA_W-1:0] rdata_q;

   assign reg_sel  = ctrl_reg_e'(lat_req.addr.ctrl.reg_idx);
   assign clear    = ctrl_start && lat_req.we && (reg_sel == reg_invalidate);
   // ordered like the register map
   assign events   = {write, read_miss, read_hit};
   assign ctrl_rsp = '{done: done_q, rdata: rdata_q};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         done_q     <= 1'b0;
         invalidate <= 1'b0;
         for (int i = 0; i < 3; i++)
            cnt[i] <= '0;
      end else begin
         done_q     <= ctrl_start;
         invalidate <= clear;
         for (int i = 0; i < 3; i++)
            if (clear)
               cnt[i] <= '0;
            else if (events[i] && cnt[i] != '1)
               cnt[i] <= cnt[i] + 1'b1;
      end
   end

   // register read path, invalidate reads as zero
   always_ff @(posedge clk) begin
      if (ctrl_start)
         rdata_q <= (reg_sel == reg_invalidate) ? '0 : cnt[reg_sel];
   end

endmodule

// ==== verilog/cache_cpu_pkg.sv ====
package cache_cpu_pkg;

`include "cache_defines.svh"

   // word address seen as a cache access
   typedef struct packed {
      logic                         is_ctrl;
      logic [`TAG_W-1:0]            tag;
      logic [`NLINES_W-1:0]         index;
      logic [`WORD_OFFSET_W-1:0]    offset;
   } data_view_t;

   // same word seen as a control register access
   typedef struct packed {
      logic                                            is_ctrl;
      logic [`ADDR_W-`NBYTES_W-`CTRL_ADDR_W-1:0]       pad;
      logic [`CTRL_ADDR_W-1:0]                         reg_idx;
   } ctrl_view_t;

   typedef union packed {
      data_view_t data;
      ctrl_view_t ctrl;
   } cpu_addr_u;

   typedef struct packed {
      logic                  we;
      cpu_addr_u             addr;
      logic [`DATA_W-1:0]    wdata;
      logic [`NBYTES-1:0]    wstrb;
   } cpu_req_t;

   typedef struct packed {
      logic                  done;
      logic [`DATA_W-1:0]    rdata;
   } part_rsp_t;

   typedef enum logic [`CTRL_ADDR_W-1:0] {
      reg_read_hits   = 2'd0,
      reg_read_misses = 2'd1,
      reg_writes      = 2'd2,
      reg_invalidate  = 2'd3
   } ctrl_reg_e;

endpackage

// ==== verilog/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// data space and word geometry
`define ADDR_W 16
`define DATA_W 32
`define NBYTES 4
`define NBYTES_W 2

// 16 lines of 4 words
`define NLINES_W 4
`define WORD_OFFSET_W 2

// tag is what is left above index, offset and byte select
`define TAG_W (`ADDR_W - `NLINES_W - `WORD_OFFSET_W - `NBYTES_W)

// control register index
`define CTRL_ADDR_W 2

`endif

// ==== verilog/cache_front_end.sv ====
`timescale 1ns/10ps

`include "cache_defines.svh"

module cache_front_end
   import cache_cpu_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req,
   output logic               ack,
   input  cpu_req_t           cpu_req,
   output logic [`DATA_W-1:0] rdata,
   output cpu_req_t           lat_req,
   output logic               data_start,
   output logic               ctrl_start,
   input  part_rsp_t          data_rsp,
   input  part_rsp_t          ctrl_rsp
);

   typedef enum logic [1:0] {st_idle, st_busy, st_acking} state_t;

   state_t    state;
   part_rsp_t reply;

   // only one part is ever running, so take the one reporting done
   assign reply = data_rsp.done ? data_rsp : ctrl_rsp;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= st_idle;
         ack        <= 1'b0;
         data_start <= 1'b0;
         ctrl_start <= 1'b0;
      end else begin
         data_start <= 1'b0;
         ctrl_start <= 1'b0;
         case (state)
            st_idle: if (req && !ack) begin
               data_start <= !cpu_req.addr.ctrl.is_ctrl;
               ctrl_start <= cpu_req.addr.ctrl.is_ctrl;
               state      <= st_busy;
            end
            st_busy: if (reply.done) begin
               ack   <= 1'b1;
               state <= st_acking;
            end
            // hold ack while the CPU keeps req up
            st_acking: if (!req) begin
               ack   <= 1'b0;
               state <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == st_idle && req && !ack)
         lat_req <= cpu_req;
      if (state == st_busy && reply.done)
         rdata <= reply.rdata;
   end

endmodule

// ==== verilog/cache_mem_pkg.sv ====
package cache_mem_pkg;

`include "cache_defines.svh"

   // one word transfer toward external memory
   typedef struct packed {
      logic                            we;
      logic [`ADDR_W-`NBYTES_W-1:0]    addr;
      logic [`DATA_W-1:0]              wdata;
      logic [`NBYTES-1:0]              wstrb;
   } mem_req_t;

   // only read data comes back, ack travels separately
   typedef struct packed {
      logic [`DATA_W-1:0]              rdata;
   } mem_rsp_t;

endpackage

// ==== verilog/cache_memory.sv ====
`timescale 1ns/10ps

`include "cache_defines.svh"

module cache_memory
   import cache_cpu_pkg::*;
   import cache_mem_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  cpu_req_t  lat_req,
   input  logic      data_start,
   output part_rsp_t data_rsp,
   input  logic      invalidate,
   output logic      read_hit,
   output logic      read_miss,
   output logic      write,
   output logic      be_start,
   output mem_req_t  be_cmd,
   input  logic      be_done,
   input  mem_rsp_t  be_rsp
);

   typedef enum logic [1:0] {st_idle, st_compare, st_fill, st_write} state_t;

   logic [`TAG_W-1:0]          tag_mem  [0:(1 << `NLINES_W)-1];
   logic [`DATA_W-1:0]         data_mem [0:(1 << (`NLINES_W + `WORD_OFFSET_W))-1];
   logic [(1 << `NLINES_W)-1:0] valid;

   state_t                     state;
   logic [`WORD_OFFSET_W-1:0]  fill_cnt;
   logic                       done_q;
   logic [`DATA_W-1:0]         rdata_q;
   logic [`TAG_W-1:0]          tag_q;
   logic                       valid_q;
   logic [`DATA_W-1:0]         word_q;
   logic [`DATA_W-1:0]         merged;
   logic                       hit;
   logic                       fill_beat;
   logic                       fill_last;
   logic                       wr_beat;

   assign hit       = valid_q && (tag_q == lat_req.addr.data.tag);
   assign fill_beat = (state == st_fill) && be_done;
   assign fill_last = fill_beat && (fill_cnt == '1);
   assign wr_beat   = (state == st_write) && be_done;
   assign data_rsp  = '{done: done_q, rdata: rdata_q};

   // strobed bytes over the cached word
   always_comb begin
      merged = word_q;
      for (int b = 0; b < `NBYTES; b++)
         if (lat_req.wstrb[b])
            merged[8*b +: 8] = lat_req.wdata[8*b +: 8];
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= st_idle;
         fill_cnt  <= '0;
         done_q    <= 1'b0;
         read_hit  <= 1'b0;
         read_miss <= 1'b0;
         write     <= 1'b0;
         be_start  <= 1'b0;
         valid     <= '0;
      end else begin
         done_q    <= 1'b0;
         read_hit  <= 1'b0;
         read_miss <= 1'b0;
         write     <= 1'b0;
         be_start  <= 1'b0;
         case (state)
            st_idle: if (data_start) state <= st_compare;
            st_compare: begin
               if (lat_req.we) begin
                  write    <= 1'b1;
                  be_start <= 1'b1;
                  state    <= st_write;
               end else if (hit) begin
                  read_hit <= 1'b1;
                  done_q   <= 1'b1;
                  state    <= st_idle;
               end else begin
                  read_miss <= 1'b1;
                  be_start  <= 1'b1;
                  fill_cnt  <= '0;
                  state     <= st_fill;
               end
            end
            st_fill: if (be_done) begin
               fill_cnt <= fill_cnt + 1'b1;
               if (fill_cnt == '1) begin
                  done_q <= 1'b1;
                  state  <= st_idle;
               end else begin
                  be_start <= 1'b1;
               end
            end
            st_write: if (be_done) begin
               done_q <= 1'b1;
               state  <= st_idle;
            end
            default: state <= st_idle;
         endcase
         if (invalidate)
            valid <= '0;
         else if (fill_last)
            valid[lat_req.addr.data.index] <= 1'b1;
      end
   end

   // array lookup and back-end command
   always_ff @(posedge clk) begin
      if (state == st_idle && data_start) begin
         tag_q   <= tag_mem[lat_req.addr.data.index];
         valid_q <= valid[lat_req.addr.data.index];
         word_q  <= data_mem[{lat_req.addr.data.index, lat_req.addr.data.offset}];
      end
      if (state == st_compare) begin
         if (lat_req.we)
            be_cmd <= '{we: 1'b1, addr: {lat_req.addr.data.tag, lat_req.addr.data.index,
                                         lat_req.addr.data.offset},
                        wdata: lat_req.wdata, wstrb: lat_req.wstrb};
         else if (hit)
            rdata_q <= word_q;
         else
            // line fill starts at word 0
            be_cmd <= '{we: 1'b0, addr: {lat_req.addr.data.tag, lat_req.addr.data.index,
                                         {`WORD_OFFSET_W{1'b0}}},
                        wdata: '0, wstrb: '0};
      end
      if (fill_beat) begin
         be_cmd.addr[`WORD_OFFSET_W-1:0] <= fill_cnt + 1'b1;
         if (fill_cnt == lat_req.addr.data.offset)
            rdata_q <= be_rsp.rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_beat)
         data_mem[{lat_req.addr.data.index, fill_cnt}] <= be_rsp.rdata;
      else if (wr_beat && hit)
         data_mem[{lat_req.addr.data.index, lat_req.addr.data.offset}] <= merged;
      if (fill_last)
         tag_mem[lat_req.addr.data.index] <= lat_req.addr.data.tag;
   end

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/10ps

`include "cache_defines.svh"

module cache_top
   import cache_cpu_pkg::*;
   import cache_mem_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req,
   output logic               ack,
   input  cpu_req_t           cpu_req,
   output logic [`DATA_W-1:0] rdata,
   output logic               mem_req,
   input  logic               mem_ack,
   output mem_req_t           mem_cmd,
   input  mem_rsp_t           mem_rsp,
   input  logic               invalidate_in,
   output logic               invalidate_out
);

   cpu_req_t  lat_req;
   logic      data_start, ctrl_start;
   part_rsp_t data_rsp, ctrl_rsp;
   logic      read_hit, read_miss, write;
   logic      ctrl_invalidate;
   logic      be_start, be_done;
   mem_req_t  be_cmd;
   mem_rsp_t  be_rsp;

   // local invalidate joins the chain
   assign invalidate_out = ctrl_invalidate | invalidate_in;

   cache_front_end front_end (.clk, .rst_n, .req, .ack, .cpu_req, .rdata, .lat_req,
                              .data_start, .ctrl_start, .data_rsp, .ctrl_rsp);

   cache_memory cache_memory (.clk, .rst_n, .lat_req, .data_start, .data_rsp,
                              .invalidate(invalidate_out), .read_hit, .read_miss, .write,
                              .be_start, .be_cmd, .be_done, .be_rsp);

   cache_control cache_control (.clk, .rst_n, .lat_req, .ctrl_start, .ctrl_rsp, .read_hit,
                                .read_miss, .write, .invalidate(ctrl_invalidate));

   cache_back_end back_end (.clk, .rst_n, .be_start, .be_cmd, .be_done, .be_rsp, .mem_req,
                            .mem_ack, .mem_cmd, .mem_rsp);

endmodule
